// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr_system
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/csr_system.sv ====
`timescale 1ns/100ps

module csr_system
    import rv_pkg::*;
    import trap_pkg::*;
#(
    parameter word_t MVENDORID = '0,
    parameter word_t MARCHID   = '0,
    parameter word_t MIMPID    = '0
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      instr_valid,
    input  instr_t    instr,
    input  addr_t     pc,

    output logic      wb_valid,
    output reg_idx_t  wb_rd,
    output word_t     wb_data,
    output logic      trap_valid,
    output trap_rec_t trap_rec,
    output redirect_t redirect,
    output logic      retired
);

    sys_op_e   op;
    csr_req_t  req;
    word_t     rs1_data;
    logic      csr_valid;
    logic      csr_exc;
    word_t     csr_rdata;
    word_t     mtvec;
    logic      trap_take;
    trap_rec_t trap_rec_c;
    logic      rf_we;
    logic      inst_retired;

    assign csr_valid    = instr_valid && op == CSR;
    assign inst_retired = instr_valid && !trap_take;
    assign rf_we        = csr_valid && !trap_take && req.rd != '0;

    // ########################################
    // Datapath
    // ########################################

    sys_decode u_sys_decode (
        .instr (instr),
        .op    (op),
        .req   (req)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .raddr (req.rs1_uimm),
        .rdata (rs1_data),
        .we    (rf_we),
        .waddr (req.rd),
        .wdata (csr_rdata)      // Old CSR value goes to rd.
    );

    csrs #(
        .MVENDORID (MVENDORID),
        .MARCHID   (MARCHID),
        .MIMPID    (MIMPID)
    ) u_csrs (
        .clk          (clk),
        .rst          (rst),
        .valid        (csr_valid),
        .req          (req),
        .rs1_data     (rs1_data),
        .csr_exc      (csr_exc),
        .rdata        (csr_rdata),
        .inst_retired (inst_retired),
        .trap_take    (trap_take),
        .trap_rec     (trap_rec_c),
        .mtvec        (mtvec)
    );

    trap_ctrl u_trap_ctrl (
        .valid     (instr_valid),
        .op        (op),
        .csr_exc   (csr_exc),
        .pc        (pc),
        .instr     (instr),
        .trap_take (trap_take),
        .trap_rec  (trap_rec_c)
    );

    // ########################################
    // Output stage
    // ########################################

    always_ff @(posedge clk) begin
        wb_rd       <= req.rd;
        wb_data     <= csr_rdata;
        trap_rec    <= trap_rec_c;
        redirect.pc <= mtvec;           // mtvec as seen in the strobe cycle.
        if (rst) begin
            wb_valid       <= 1'b0;
            trap_valid     <= 1'b0;
            redirect.valid <= 1'b0;
            retired        <= 1'b0;
        end else begin
            wb_valid       <= rf_we;
            trap_valid     <= trap_take;
            redirect.valid <= trap_take;
            retired        <= inst_retired;
        end
    end

endmodule

// ==== rtl/csrs.sv ====
`timescale 1ns/100ps

module csrs
    import rv_pkg::*;
    import trap_pkg::*;
#(
    parameter word_t MVENDORID = '0,
    parameter word_t MARCHID   = '0,
    parameter word_t MIMPID    = '0
) (
    input  logic      clk,
    input  logic      rst,

    input  logic      valid,
    input  csr_req_t  req,
    input  word_t     rs1_data,
    output logic      csr_exc,
    output word_t     rdata,

    input  logic      inst_retired,

    input  logic      trap_take,
    input  trap_rec_t trap_rec,

    output word_t     mtvec
);

    localparam word_t MTVEC_MASK = ~word_t'(2);   // Bit 1 reserved, direct/vectored only.
    localparam word_t MEPC_MASK  = ~word_t'(1);

    word_t mtvec_q;
    word_t mscratch_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mtval_q;
    word_t mcycle_q;
    word_t minstret_q;

    logic  bad_addr;
    logic  read_only;
    logic  is_write;
    logic  do_write;
    word_t operand;
    word_t wdata;

    assign mtvec = mtvec_q;

    // ########################################
    // Access checks
    // ########################################

    assign read_only = req.addr[11:10] == 2'b11;

    // Set and clear with a zero source never write, so they may read read-only CSRs.
    assign is_write = (req.funct3 == CSRRW) || (req.funct3 == CSRRWI) || (req.rs1_uimm != '0);

    assign csr_exc  = bad_addr || (is_write && read_only);
    assign do_write = valid && is_write && !csr_exc;

    // ########################################
    // Read side
    // ########################################

    always_comb begin
        bad_addr = 1'b0;
        rdata    = '0;
        case (req.addr)
            CSR_MTVEC:     rdata = mtvec_q;
            CSR_MSCRATCH:  rdata = mscratch_q;
            CSR_MEPC:      rdata = mepc_q;
            CSR_MCAUSE:    rdata = mcause_q;
            CSR_MTVAL:     rdata = mtval_q;
            CSR_MCYCLE:    rdata = mcycle_q;
            CSR_MINSTRET:  rdata = minstret_q;
            CSR_CYCLE:     rdata = mcycle_q;     // User aliases.
            CSR_TIME:      rdata = mcycle_q;
            CSR_INSTRET:   rdata = minstret_q;
            CSR_MVENDORID: rdata = MVENDORID;
            CSR_MARCHID:   rdata = MARCHID;
            CSR_MIMPID:    rdata = MIMPID;
            CSR_MHARTID:   rdata = '0;           // Single hart.
            default:       bad_addr = 1'b1;
        endcase
    end

    // ########################################
    // Write data
    // ########################################

    assign operand = req.funct3[2] ? word_t'(req.rs1_uimm) : rs1_data;

    always_comb begin
        case (req.funct3)
            CSRRS, CSRRSI: wdata = rdata | operand;
            CSRRC, CSRRCI: wdata = rdata & ~operand;
            default:       wdata = operand;
        endcase
    end

    // ########################################
    // Register update
    // ########################################

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
            if (inst_retired) begin
                minstret_q <= minstret_q + 1'b1;
            end

            // An explicit write wins over the counter increment.
            if (do_write) begin
                case (req.addr)
                    CSR_MTVEC:    mtvec_q    <= wdata & MTVEC_MASK;
                    CSR_MSCRATCH: mscratch_q <= wdata;
                    CSR_MEPC:     mepc_q     <= wdata & MEPC_MASK;
                    CSR_MCAUSE:   mcause_q   <= wdata;
                    CSR_MTVAL:    mtval_q    <= wdata;
                    CSR_MCYCLE:   mcycle_q   <= wdata;
                    CSR_MINSTRET: minstret_q <= wdata;
                    default: ;
                endcase
            end

            if (trap_take) begin
                mcause_q <= word_t'(trap_rec.cause);
                mepc_q   <= trap_rec.epc & MEPC_MASK;
                mtval_q  <= trap_rec.tval;
            end
        end
    end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t raddr,
    output word_t    rdata,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [1:31];   // No storage behind x0.

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;   // Instruction address, ALEN == XLEN.
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [31:0]     instr_t;

    // ########################################
    // SYSTEM opcode encodings
    // ########################################

    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam instr_t     INSTR_ECALL  = 32'h0000_0073;
    localparam instr_t     INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_funct3_e;

    typedef enum logic [1:0] {
        CSR     = 2'd0,
        ECALL   = 2'd1,
        EBREAK  = 2'd2,
        ILLEGAL = 2'd3
    } sys_op_e;

    typedef struct packed {
        csr_addr_t   addr;
        csr_funct3_e funct3;
        reg_idx_t    rd;
        reg_idx_t    rs1_uimm;   // rs1 index, or the uimm for the I forms.
    } csr_req_t;

    // ########################################
    // Machine CSR addresses
    // ########################################

    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_TIME      = 12'hC01;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

endpackage

// ==== rtl/sys_decode.sv ====
`timescale 1ns/100ps

module sys_decode
    import rv_pkg::*;
(
    input  instr_t   instr,
    output sys_op_e  op,
    output csr_req_t req
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ########################################
    // CSR request fields
    // ########################################

    // Fields are passed on for every word, op says whether they mean anything.
    always_comb begin
        req.addr     = instr[31:20];
        req.funct3   = csr_funct3_e'(funct3);
        req.rd       = instr[11:7];
        req.rs1_uimm = instr[19:15];
    end

    // ########################################
    // Instruction kind
    // ########################################

    always_comb begin
        if (opcode != OPC_SYSTEM) begin
            op = ILLEGAL;
        end else if (funct3 == 3'b000) begin
            if (instr == INSTR_ECALL) begin
                op = ECALL;
            end else if (instr == INSTR_EBREAK) begin
                op = EBREAK;
            end else begin
                op = ILLEGAL;             // mret, wfi and friends.
            end
        end else if (funct3 == 3'b100) begin
            op = ILLEGAL;                 // Reserved funct3.
        end else begin
            op = CSR;
        end
    end

endmodule

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/100ps

module trap_ctrl
    import rv_pkg::*;
    import trap_pkg::*;
(
    input  logic      valid,
    input  sys_op_e   op,
    input  logic      csr_exc,
    input  addr_t     pc,
    input  instr_t    instr,
    output logic      trap_take,
    output trap_rec_t trap_rec
);

    logic illegal;
    logic env_call;

    // csr_exc means nothing unless the word really is a CSR access.
    assign illegal  = (op == ILLEGAL) || (op == CSR && csr_exc);
    assign env_call = (op == ECALL) || (op == EBREAK);

    assign trap_take = valid && (illegal || env_call);

    // ########################################
    // Trap record
    // ########################################

    always_comb begin
        trap_rec.epc = pc;
        if (illegal) begin
            trap_rec.cause = ILLEGAL_INSTR;
            trap_rec.tval  = instr;       // Faulting word.
        end else if (op == ECALL) begin
            trap_rec.cause = ECALL_M;
            trap_rec.tval  = '0;
        end else begin
            trap_rec.cause = BREAKPOINT;
            trap_rec.tval  = '0;
        end
    end

endmodule

// ==== rtl/trap_pkg.sv ====
package trap_pkg;

    import rv_pkg::*;

    // Exception codes, mcause with interrupt bit clear.
    typedef enum logic [3:0] {
        ILLEGAL_INSTR = 4'd2,
        BREAKPOINT    = 4'd3,
        ECALL_M       = 4'd11
    } trap_cause_e;

    // ########################################
    // Trap record and fetch redirect
    // ########################################

    typedef struct packed {
        trap_cause_e cause;   // To mcause.
        addr_t       epc;     // To mepc.
        word_t       tval;    // To mtval.
    } trap_rec_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

endpackage

// ==== sim/tb_csr_system.sv ====
`timescale 1ns/100ps

module tb_csr_system
    import rv_pkg::*;
    import trap_pkg::*;
();

    localparam int     PERIOD      = 20;
    localparam int     NUM_TESTS   = 6;
    localparam int     WATCHDOG_NS = NUM_TESTS * 200 * PERIOD;
    localparam word_t  VENDOR_ID   = 32'h0000_0B0B;
    localparam word_t  ARCH_ID     = 32'd5;
    localparam word_t  IMP_ID      = 32'd1;
    localparam instr_t ECALL_WORD  = 32'h0000_0073;
    localparam instr_t EBREAK_WORD = 32'h0010_0073;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    addr_t     pc;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    word_t     wb_data;
    logic      trap_valid;
    trap_rec_t trap_rec;
    redirect_t redirect;
    logic      retired;

    word_t lfsr;
    word_t gpr_m [0:31];
    word_t m_mtvec;
    word_t m_mscratch;
    word_t m_mepc;
    word_t m_mcause;
    word_t m_mtval;
    addr_t cur_pc;
    addr_t last_pc;
    int    retire_cnt;
    int    checks;
    int    errors;

    csr_system #(
        .MVENDORID (VENDOR_ID),
        .MARCHID   (ARCH_ID),
        .MIMPID    (IMP_ID)
    ) u_csr_system (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .trap_valid  (trap_valid),
        .trap_rec    (trap_rec),
        .redirect    (redirect),
        .retired     (retired)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ########################################
    // Stimulus helpers
    // ########################################

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic instr_t rand_nonsys();
        instr_t w;
        w = rand_bits(32);
        if (w[6:0] == 7'b1110011) begin
            w[0] = 1'b0;                  // Off the SYSTEM opcode.
        end
        return w;
    endfunction

    function automatic instr_t enc_csr(input csr_funct3_e f, input csr_addr_t a,
                                       input reg_idx_t src, input reg_idx_t rd);
        return {a, src, f, rd, 7'b1110011};
    endfunction

    task automatic issue(input instr_t w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        pc          <= cur_pc;
        last_pc      = cur_pc;
        cur_pc       = cur_pc + 32'd4;
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);                   // Results one cycle after the strobe.
    endtask

    // ########################################
    // Compare tasks
    // ########################################

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_cause(input trap_cause_e got, input trap_cause_e exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            if (exp) begin
                $display("No %s pulse came after the instruction at %0t ns.", what, $time);
            end else begin
                $display("An unexpected %s pulse came at %0t ns.", what, $time);
            end
        end
    endtask

    // ########################################
    // Access and trap checks
    // ########################################

    task automatic csr_access(input csr_funct3_e f, input csr_addr_t a, input reg_idx_t src,
                              input reg_idx_t rd, input word_t old);
        issue(enc_csr(f, a, src, rd));
        check_bit(trap_valid, 1'b0, "trap_valid");
        check_bit(retired, 1'b1, "retired");
        check_bit(wb_valid, rd != '0, "wb_valid");
        if (rd != '0) begin
            check_rd(wb_rd, rd, "wb_rd");
            check_word(wb_data, old, "wb_data");
            gpr_m[rd] = old;
        end
        retire_cnt++;
    endtask

    task automatic read_csr(input csr_addr_t a, output word_t v);
        issue(enc_csr(CSRRS, a, 5'd0, 5'd1));
        check_bit(wb_valid, 1'b1, "wb_valid");
        check_bit(retired, 1'b1, "retired");
        v        = wb_data;
        gpr_m[1] = v;
        retire_cnt++;
    endtask

    task automatic expect_trap(input trap_cause_e c, input word_t tval);
        check_bit(trap_valid, 1'b1, "trap_valid");
        check_bit(redirect.valid, 1'b1, "redirect");
        check_bit(wb_valid, 1'b0, "wb_valid");
        check_bit(retired, 1'b0, "retired");
        check_cause(trap_rec.cause, c, "cause");
        check_word(trap_rec.epc, last_pc, "epc");
        check_word(trap_rec.tval, tval, "tval");
        check_word(redirect.pc, m_mtvec, "redirect pc");
        m_mcause = word_t'(c);
        m_mepc   = last_pc & 32'hFFFF_FFFE;
        m_mtval  = tval;
    endtask

    // Illegal word lands in mtval, then a read moves it into a register.
    task automatic load_gpr(input reg_idx_t r, input instr_t v);
        issue(v);
        expect_trap(ILLEGAL_INSTR, v);
        csr_access(CSRRS, CSR_MTVAL, 5'd0, r, m_mtval);
    endtask

    // ########################################
    // Directed tests
    // ########################################

    task automatic test_reset_ids();
        @(negedge clk);
        check_bit(wb_valid, 1'b0, "wb_valid");
        check_bit(trap_valid, 1'b0, "trap_valid");
        check_bit(redirect.valid, 1'b0, "redirect");
        check_bit(retired, 1'b0, "retired");
        csr_access(CSRRS, CSR_MVENDORID, 5'd0, 5'd1, VENDOR_ID);
        csr_access(CSRRS, CSR_MARCHID, 5'd0, 5'd2, ARCH_ID);
        csr_access(CSRRS, CSR_MIMPID, 5'd0, 5'd3, IMP_ID);
        csr_access(CSRRS, CSR_MHARTID, 5'd0, 5'd4, 32'd0);
        csr_access(CSRRS, CSR_MTVEC, 5'd0, 5'd5, 32'd0);
    endtask

    task automatic test_rmw();
        reg_idx_t u;
        load_gpr(5'd5, rand_nonsys());
        load_gpr(5'd6, rand_nonsys());
        load_gpr(5'd7, rand_nonsys());
        csr_access(CSRRW, CSR_MSCRATCH, 5'd5, 5'd10, m_mscratch);
        m_mscratch = gpr_m[5];
        csr_access(CSRRS, CSR_MSCRATCH, 5'd6, 5'd11, m_mscratch);
        m_mscratch = m_mscratch | gpr_m[6];
        csr_access(CSRRC, CSR_MSCRATCH, 5'd7, 5'd0, m_mscratch);
        m_mscratch = m_mscratch & ~gpr_m[7];
        u = reg_idx_t'(rand_bits(5));
        csr_access(CSRRWI, CSR_MSCRATCH, u, 5'd12, m_mscratch);
        m_mscratch = word_t'(u);
        u = reg_idx_t'(rand_bits(5));
        csr_access(CSRRSI, CSR_MSCRATCH, u, 5'd13, m_mscratch);
        m_mscratch = m_mscratch | word_t'(u);
        u = reg_idx_t'(rand_bits(5));
        csr_access(CSRRCI, CSR_MSCRATCH, u, 5'd0, m_mscratch);
        m_mscratch = m_mscratch & ~word_t'(u);
        csr_access(CSRRS, CSR_MSCRATCH, 5'd0, 5'd14, m_mscratch);
    endtask

    task automatic test_mask();
        load_gpr(5'd8, 32'hFFFF_FFFF);
        csr_access(CSRRW, CSR_MTVEC, 5'd8, 5'd0, m_mtvec);
        m_mtvec = 32'hFFFF_FFFD;
        csr_access(CSRRS, CSR_MTVEC, 5'd0, 5'd9, 32'hFFFF_FFFD);
        csr_access(CSRRW, CSR_MEPC, 5'd8, 5'd0, m_mepc);
        m_mepc = 32'hFFFF_FFFE;
        csr_access(CSRRS, CSR_MEPC, 5'd0, 5'd9, 32'hFFFF_FFFE);
    endtask

    task automatic test_illegal();
        instr_t w;
        w = enc_csr(CSRRW, CSR_MVENDORID, 5'd5, 5'd1);
        issue(w);
        expect_trap(ILLEGAL_INSTR, w);
        w = enc_csr(CSRRS, 12'h7C0, 5'd0, 5'd1);
        issue(w);
        expect_trap(ILLEGAL_INSTR, w);
        w = {CSR_MSCRATCH, 5'd0, 3'b100, 5'd1, 7'b1110011};
        issue(w);
        expect_trap(ILLEGAL_INSTR, w);
        w = rand_nonsys();
        issue(w);
        expect_trap(ILLEGAL_INSTR, w);
        csr_access(CSRRS, CSR_MVENDORID, 5'd0, 5'd2, VENDOR_ID);
    endtask

    task automatic test_calls();
        load_gpr(5'd9, rand_nonsys());
        csr_access(CSRRW, CSR_MTVEC, 5'd9, 5'd0, m_mtvec);
        m_mtvec = gpr_m[9] & 32'hFFFF_FFFD;
        issue(ECALL_WORD);
        expect_trap(ECALL_M, 32'd0);
        csr_access(CSRRS, CSR_MEPC, 5'd0, 5'd3, m_mepc);
        csr_access(CSRRS, CSR_MCAUSE, 5'd0, 5'd3, m_mcause);
        csr_access(CSRRS, CSR_MTVAL, 5'd0, 5'd3, m_mtval);
        issue(EBREAK_WORD);
        expect_trap(BREAKPOINT, 32'd0);
        csr_access(CSRRS, CSR_MEPC, 5'd0, 5'd4, m_mepc);
        csr_access(CSRRS, CSR_MCAUSE, 5'd0, 5'd4, m_mcause);
        csr_access(CSRRS, CSR_MTVAL, 5'd0, 5'd4, m_mtval);
    endtask

    task automatic test_counters();
        word_t a;
        word_t b;
        int    k0;
        read_csr(CSR_MCYCLE, a);
        repeat (5) @(posedge clk);
        read_csr(CSR_MCYCLE, b);
        check_word(b - a, 32'd7, "mcycle delta");    // Five idle cycles plus issue spacing.
        k0 = retire_cnt;
        read_csr(CSR_INSTRET, a);
        csr_access(CSRRS, CSR_MSCRATCH, 5'd0, 5'd6, m_mscratch);
        issue(ECALL_WORD);
        expect_trap(ECALL_M, 32'd0);
        csr_access(CSRRS, CSR_MHARTID, 5'd0, 5'd7, 32'd0);
        load_gpr(5'd8, rand_nonsys());
        read_csr(CSR_INSTRET, b);
        check_word(b - a, word_t'(retire_cnt - 1 - k0), "instret delta");
        read_csr(CSR_CYCLE, a);
        read_csr(CSR_MCYCLE, b);
        check_word(b - a, 32'd2, "cycle alias");
    endtask

    // ########################################
    // Main sequence and watchdog
    // ########################################

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        lfsr        = 32'h03843fe7;
        cur_pc      = 32'h0000_0400;
        last_pc     = '0;
        m_mtvec     = '0;
        m_mscratch  = '0;
        m_mepc      = '0;
        m_mcause    = '0;
        m_mtval     = '0;
        retire_cnt  = 0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 32; i++) begin
            gpr_m[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_ids();
        test_rmw();
        test_mask();
        test_illegal();
        test_calls();
        test_counters();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/rv_pkg.sv
rtl/trap_pkg.sv
rtl/sys_decode.sv
rtl/regfile.sv
rtl/csrs.sv
rtl/trap_ctrl.sv
rtl/csr_system.sv
sim/tb_csr_system.sv
